// ==== Makefile ====
TOP := tb_pool_top
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qx "Finished with no errors" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== pool_cfg_pkg.sv ====
package pool_cfg_pkg;

  ////////////////////////////////////////
  // size limits
  ////////////////////////////////////////
  localparam int MAX_WIDTH  = 64;               // widest image row in pixels
  localparam int DIM_W      = 8;                // width and height fields
  localparam int LB_DEPTH   = MAX_WIDTH / 2;    // one entry per column pair
  localparam int LB_AW      = $clog2(LB_DEPTH);

  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 32;

  typedef enum logic {
    POOL_MAX = 1'b0,
    POOL_AVG = 1'b1
  } pool_method_e;

  // register map, word addresses
  typedef enum logic [CFG_ADDR_W-1:0] {
    REG_CTRL   = 2'd0,  // [0] enable, [1] method
    REG_WIDTH  = 2'd1,
    REG_HEIGHT = 2'd2,
    REG_STATUS = 2'd3   // [0] busy, read-only
  } cfg_reg_e;

  typedef struct packed {
    logic             enable;
    pool_method_e     method;
    logic [DIM_W-1:0] width;
    logic [DIM_W-1:0] height;
  } pool_cfg_t;

endpackage

// ==== pool_cfg_regs.sv ====
`timescale 1ns/1ps

module pool_cfg_regs import pool_cfg_pkg::*;
(
  input  logic                  clk_fast_i,
  input  logic                  rst_n,
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
  input  logic                  busy_i,
  output logic                  cfg_gnt_o,
  output logic                  cfg_r_valid_o,
  output logic [CFG_DATA_W-1:0] cfg_r_data_o,
  output pool_cfg_t             cfg_o
);

  cfg_reg_e              addr;
  pool_cfg_t             cfg_q;
  logic [CFG_DATA_W-1:0] rd_word;

  assign addr      = cfg_reg_e'(cfg_addr_i);
  assign cfg_gnt_o = cfg_req_i;  // every request taken at once
  assign cfg_o     = cfg_q;

  always_comb begin
    rd_word = '0;
    case (addr)
      REG_CTRL:   rd_word[1:0]       = {cfg_q.method, cfg_q.enable};
      REG_WIDTH:  rd_word[DIM_W-1:0] = cfg_q.width;
      REG_HEIGHT: rd_word[DIM_W-1:0] = cfg_q.height;
      REG_STATUS: rd_word[0]         = busy_i;
      default:    rd_word            = '0;
    endcase
  end

  // config locked while a frame is in flight
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (cfg_req_i && cfg_we_i && !busy_i) begin
      case (addr)
        REG_CTRL: begin
          cfg_q.enable <= cfg_wdata_i[0];
          cfg_q.method <= pool_method_e'(cfg_wdata_i[1]);
        end
        REG_WIDTH:  cfg_q.width  <= cfg_wdata_i[DIM_W-1:0];
        REG_HEIGHT: cfg_q.height <= cfg_wdata_i[DIM_W-1:0];
        default:    cfg_q        <= cfg_q;  // status has no storage
      endcase
    end
  end

  ////////////////////////////////////////
  // response, one cycle after grant
  ////////////////////////////////////////
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      cfg_r_valid_o <= 1'b0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (cfg_req_i) begin
      cfg_r_data_o <= cfg_we_i ? '0 : rd_word;  // writes answer zero
    end
  end

endmodule

// ==== pool_input_slice.sv ====
`timescale 1ns/1ps

module pool_input_slice import pool_stream_pkg::*;
(
  input  logic               clk_fast_i,
  input  logic               rst_n,
  input  beat_vec_t          s_beat_i,
  output logic [N_LANES-1:0] s_ready_o,
  output beat_vec_t          m_beat_o,
  input  logic [N_LANES-1:0] m_ready_i
);

  // one-entry register per lane, lanes stall independently
  for (genvar g = 0; g < N_LANES; g++) begin : slice_gen
    logic vld_q;
    pix_t data_q;

    // free when empty or drained this cycle
    assign s_ready_o[g] = !vld_q || m_ready_i[g];
    assign m_beat_o[g]  = '{valid: vld_q, data: data_q};

    always_ff @(posedge clk_fast_i or negedge rst_n) begin
      if (!rst_n) begin
        vld_q <= 1'b0;
      end else if (s_ready_o[g]) begin
        vld_q <= s_beat_i[g].valid;
      end
    end

    always_ff @(posedge clk_fast_i) begin
      if (s_ready_o[g] && s_beat_i[g].valid) begin
        data_q <= s_beat_i[g].data;
      end
    end
  end

endmodule

// ==== pool_lane.sv ====
`timescale 1ns/1ps

module pool_lane import pool_cfg_pkg::*, pool_stream_pkg::*;
(
  input  logic      clk_fast_i,
  input  logic      rst_n,
  input  pool_cfg_t cfg_i,
  input  beat_t     in_beat_i,
  output logic      in_ready_o,
  output beat_t     out_beat_o,
  input  logic      out_ready_i
);

  logic [DIM_W-1:0]        col_q;
  logic [DIM_W-1:0]        row_q;
  logic                    col_last;
  logic                    row_last;
  logic                    emit;        // current pixel yields a result
  logic                    accept;
  logic [LB_AW-1:0]        lb_idx;
  pix_t                    prev_q;      // left pixel of the pair
  pix_t                    pair_max;
  logic signed [SUM_W-1:0] pair_val;
  logic signed [SUM_W-1:0] top_val;
  logic signed [SUM_W-1:0] quad_sum;
  logic signed [SUM_W-1:0] win_max;
  logic signed [SUM_W-1:0] line_mem [LB_DEPTH];
  pix_t                    result;
  logic                    out_vld_q;
  pix_t                    out_data_q;

  assign col_last = (col_q == cfg_i.width - DIM_W'(1));
  assign row_last = (row_q == cfg_i.height - DIM_W'(1));
  assign emit     = !cfg_i.enable || (row_q[0] && col_q[0]);

  // stall only if this pixel would overwrite a pending result
  assign in_ready_o = !(out_vld_q && !out_ready_i && emit);
  assign accept     = in_beat_i.valid && in_ready_o;

  ////////////////////////////////////////
  // window arithmetic
  ////////////////////////////////////////
  assign lb_idx   = col_q[LB_AW:1];
  assign pair_max = (prev_q > in_beat_i.data) ? prev_q : in_beat_i.data;
  assign pair_val = (cfg_i.method == POOL_MAX) ? SUM_W'(pair_max)
                                               : SUM_W'(prev_q) + SUM_W'(in_beat_i.data);
  assign top_val  = line_mem[lb_idx];  // pair from the even row above
  assign quad_sum = top_val + pair_val;
  assign win_max  = (top_val > pair_val) ? top_val : pair_val;

  always_comb begin
    if (!cfg_i.enable) begin
      result = in_beat_i.data;
    end else if (cfg_i.method == POOL_MAX) begin
      result = win_max[PIX_W-1:0];
    end else begin
      result = quad_sum[SUM_W-1:2];  // >>> 2, rounds toward -inf
    end
  end

  // position in the frame, row-major
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      if (col_last) begin
        col_q <= '0;
        row_q <= row_last ? '0 : row_q + DIM_W'(1);
      end else begin
        col_q <= col_q + DIM_W'(1);
      end
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (accept && !col_q[0]) begin
      prev_q <= in_beat_i.data;
    end
    if (accept && col_q[0] && !row_q[0]) begin
      line_mem[lb_idx] <= pair_val;  // even row, keep half-window
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_q <= 1'b0;
    end else if (accept && emit) begin
      out_vld_q <= 1'b1;
    end else if (out_ready_i) begin
      out_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (accept && emit) begin
      out_data_q <= result;
    end
  end

  assign out_beat_o = '{valid: out_vld_q, data: out_data_q};

endmodule

// ==== pool_output_collect.sv ====
`timescale 1ns/1ps

module pool_output_collect import pool_cfg_pkg::*, pool_stream_pkg::*;
(
  input  logic               clk_fast_i,
  input  logic               rst_n,
  input  pool_cfg_t          cfg_i,
  input  beat_vec_t          lane_beat_i,
  output logic [N_LANES-1:0] lane_ready_o,
  output beat_vec_t          m_beat_o,
  input  logic [N_LANES-1:0] m_ready_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               evt_interrupt_o
);

  logic [DIM_W-1:0] out_w;
  logic [DIM_W-1:0] out_h;
  logic [CNT_W-1:0] expected;
  logic [CNT_W-1:0] n_xfer;    // results taken this cycle
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic             busy_q;
  logic             evt_q;
  logic             done;

  assign m_beat_o     = lane_beat_i;
  assign lane_ready_o = m_ready_i;

  // results per lane shrink by four when pooling
  assign out_w    = cfg_i.enable ? cfg_i.width >> 1 : cfg_i.width;
  assign out_h    = cfg_i.enable ? cfg_i.height >> 1 : cfg_i.height;
  assign expected = CNT_W'(N_LANES) * CNT_W'(out_w) * CNT_W'(out_h);

  always_comb begin
    n_xfer = '0;
    for (int l = 0; l < N_LANES; l++) begin
      if (lane_beat_i[l].valid && m_ready_i[l]) begin
        n_xfer = n_xfer + CNT_W'(1);
      end
    end
  end

  assign cnt_next = cnt_q + n_xfer;
  assign done     = busy_q && (n_xfer != '0) && (cnt_next == expected);

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      evt_q  <= 1'b0;
    end else begin
      evt_q <= done;  // one cycle after the last transfer
      if (done) begin
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_next;
      end else if (start_i) begin
        busy_q <= 1'b1;
      end
    end
  end

  assign busy_o          = busy_q;
  assign evt_interrupt_o = evt_q;

endmodule

// ==== pool_stream_pkg.sv ====
package pool_stream_pkg;

  localparam int N_LANES = 4;   // one per engine output stream
  localparam int PIX_W   = 16;

  // four-pixel sum needs two guard bits
  localparam int SUM_W   = PIX_W + 2;

  // results per frame over all lanes, covers 4 x 255 x 255
  localparam int CNT_W   = 20;

  typedef logic signed [PIX_W-1:0] pix_t;

  ////////////////////////////////////////
  // stream beat, forward half only
  ////////////////////////////////////////
  typedef struct packed {
    logic valid;
    pix_t data;
  } beat_t;

  typedef beat_t [N_LANES-1:0] beat_vec_t;

endpackage

// ==== pool_top.sv ====
`timescale 1ns/1ps

module pool_top import pool_cfg_pkg::*, pool_stream_pkg::*;
(
  input  logic                  clk_fast_i,
  input  logic                  rst_n,
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
  output logic                  cfg_gnt_o,
  output logic                  cfg_r_valid_o,
  output logic [CFG_DATA_W-1:0] cfg_r_data_o,
  input  beat_vec_t             s_beat_i,
  output logic [N_LANES-1:0]    s_ready_o,
  output beat_vec_t             m_beat_o,
  input  logic [N_LANES-1:0]    m_ready_i,
  output logic                  evt_interrupt_o
);

  pool_cfg_t          cfg;
  logic               busy;
  logic               start;        // any input transfer
  beat_vec_t          slice_beat;
  logic [N_LANES-1:0] slice_ready;
  beat_vec_t          lane_beat;
  logic [N_LANES-1:0] lane_ready;

  always_comb begin
    start = 1'b0;
    for (int l = 0; l < N_LANES; l++) begin
      start = start | (s_beat_i[l].valid & s_ready_o[l]);
    end
  end

  pool_cfg_regs i_cfg_regs (
    .clk_fast_i    (clk_fast_i),
    .rst_n         (rst_n),
    .cfg_req_i     (cfg_req_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .busy_i        (busy),
    .cfg_gnt_o     (cfg_gnt_o),
    .cfg_r_valid_o (cfg_r_valid_o),
    .cfg_r_data_o  (cfg_r_data_o),
    .cfg_o         (cfg)
  );

  pool_input_slice i_input_slice (
    .clk_fast_i (clk_fast_i),
    .rst_n      (rst_n),
    .s_beat_i   (s_beat_i),
    .s_ready_o  (s_ready_o),
    .m_beat_o   (slice_beat),
    .m_ready_i  (slice_ready)
  );

  ////////////////////////////////////////
  // pooling lanes
  ////////////////////////////////////////
  for (genvar g = 0; g < N_LANES; g++) begin : lane_gen
    pool_lane i_lane (
      .clk_fast_i  (clk_fast_i),
      .rst_n       (rst_n),
      .cfg_i       (cfg),
      .in_beat_i   (slice_beat[g]),
      .in_ready_o  (slice_ready[g]),
      .out_beat_o  (lane_beat[g]),
      .out_ready_i (lane_ready[g])
    );
  end

  pool_output_collect i_output_collect (
    .clk_fast_i      (clk_fast_i),
    .rst_n           (rst_n),
    .cfg_i           (cfg),
    .lane_beat_i     (lane_beat),
    .lane_ready_o    (lane_ready),
    .m_beat_o        (m_beat_o),
    .m_ready_i       (m_ready_i),
    .start_i         (start),
    .busy_o          (busy),
    .evt_interrupt_o (evt_interrupt_o)
  );

endmodule

// ==== pool_top_sva.sv ====
`timescale 1ns/1ps

module pool_top_sva import pool_stream_pkg::*;
(
  input logic               clk_fast_i,
  input logic               rst_n,
  input beat_vec_t          s_beat_i,
  input logic [N_LANES-1:0] s_ready_o,
  input beat_vec_t          m_beat_o,
  input logic [N_LANES-1:0] m_ready_i,
  input logic               evt_interrupt_o
);

  logic [N_LANES-1:0] m_vld;

  for (genvar g = 0; g < N_LANES; g++) begin : lane_chk
    assign m_vld[g] = m_beat_o[g].valid;

    // a stalled beat holds until taken
    in_stable: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
      s_beat_i[g].valid && !s_ready_o[g] |=> s_beat_i[g].valid && $stable(s_beat_i[g].data))
      else $error("input beat on lane %0d changed while stalled", g);

    out_stable: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
      m_beat_o[g].valid && !m_ready_i[g] |=> m_beat_o[g].valid && $stable(m_beat_o[g].data))
      else $error("output beat on lane %0d changed while stalled", g);
  end

  evt_single: assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    evt_interrupt_o |=> !evt_interrupt_o)
    else $error("frame event longer than one cycle");

  // nothing leaves the outputs right after reset
  out_idle_after_reset: assert property (@(posedge clk_fast_i) $rose(rst_n) |-> m_vld == '0)
    else $error("output valid high in the first cycle after reset");

endmodule

bind pool_top pool_top_sva i_sva (
  .clk_fast_i      (clk_fast_i),
  .rst_n           (rst_n),
  .s_beat_i        (s_beat_i),
  .s_ready_o       (s_ready_o),
  .m_beat_o        (m_beat_o),
  .m_ready_i       (m_ready_i),
  .evt_interrupt_o (evt_interrupt_o)
);

// ==== tb_pool_top.sv ====
`timescale 1ns/1ps

module tb_pool_top import pool_cfg_pkg::*, pool_stream_pkg::*;
();

  typedef struct packed {
    logic             enable;
    pool_method_e     method;
    logic [DIM_W-1:0] width;
    logic [DIM_W-1:0] height;
    logic             rand_rdy;  // random m_ready_i
  } frame_t;

  localparam int N_FRAMES = 8;
  // enable, method, width, height, random ready
  localparam frame_t FRAMES [N_FRAMES] = '{
    '{1'b0, POOL_MAX, 8'd6,  8'd3, 1'b0},   // bypass
    '{1'b1, POOL_MAX, 8'd8,  8'd4, 1'b0},
    '{1'b1, POOL_MAX, 8'd12, 8'd6, 1'b0},
    '{1'b1, POOL_MAX, 8'd64, 8'd2, 1'b0},   // full line buffer
    '{1'b1, POOL_AVG, 8'd10, 8'd4, 1'b0},
    '{1'b1, POOL_MAX, 8'd8,  8'd6, 1'b1},
    '{1'b1, POOL_AVG, 8'd16, 8'd4, 1'b1},
    '{1'b0, POOL_MAX, 8'd5,  8'd4, 1'b1}
  };

  logic                  clk_fast_i;
  logic                  rst_n;
  logic                  cfg_req_i;
  logic                  cfg_we_i;
  logic [CFG_ADDR_W-1:0] cfg_addr_i;
  logic [CFG_DATA_W-1:0] cfg_wdata_i;
  logic                  cfg_gnt_o;
  logic                  cfg_r_valid_o;
  logic [CFG_DATA_W-1:0] cfg_r_data_o;
  beat_vec_t             s_beat_i;
  logic [N_LANES-1:0]    s_ready_o;
  beat_vec_t             m_beat_o;
  logic [N_LANES-1:0]    m_ready_i;
  logic                  evt_interrupt_o;

  logic [31:0] lfsr_q = 32'h1c21_3c29;
  pix_t        in_q  [N_LANES][$];  // pixels still to send
  pix_t        exp_q [N_LANES][$];  // results still to see
  int          cur_frame = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 200;

  pool_top i_dut (.*);

  initial begin
    clk_fast_i = 1'b0;
    forever #5 clk_fast_i = ~clk_fast_i;
  end

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_pix(input string name, input pix_t got, input pix_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cfg_word(input string name, input logic [CFG_DATA_W-1:0] got,
                                input logic [CFG_DATA_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_event(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch evt_interrupt_o: got %h expected %h", got, exp));
    end
  endtask

  always @(posedge clk_fast_i) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      report_failure($sformatf("timeout: frame %0d did not complete within %0d cycles",
                               cur_frame, timeout_limit));
    end
  end

  // galois lfsr with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  function automatic pix_t max4(input pix_t a, input pix_t b, input pix_t c, input pix_t d);
    pix_t m;
    m = a;
    if (b > m) m = b;
    if (c > m) m = c;
    if (d > m) m = d;
    return m;
  endfunction

  ////////////////////////////////////////
  // configuration port
  ////////////////////////////////////////
  task automatic cfg_access(input logic we, input cfg_reg_e addr,
                            input logic [CFG_DATA_W-1:0] wdata,
                            output logic [CFG_DATA_W-1:0] rdata);
    @(posedge clk_fast_i);
    #1;
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    s_beat_i    = '0;  // streams paused
    m_ready_i   = '0;
    @(negedge clk_fast_i);
    if (!cfg_gnt_o) begin
      report_failure($sformatf("no grant in the request cycle for %s", addr.name()));
    end
    if (cfg_r_valid_o) begin
      report_failure($sformatf("response valid already in the request cycle for %s",
                               addr.name()));
    end
    @(posedge clk_fast_i);
    #1;
    cfg_req_i = 1'b0;
    @(negedge clk_fast_i);
    if (!cfg_r_valid_o) begin
      report_failure($sformatf("no response one cycle after the grant for %s", addr.name()));
    end
    rdata = cfg_r_data_o;
  endtask

  task automatic cfg_write(input cfg_reg_e addr, input logic [CFG_DATA_W-1:0] data);
    logic [CFG_DATA_W-1:0] rd;
    cfg_access(1'b1, addr, data, rd);
    check_cfg_word("cfg_r_data_o on write", rd, '0);
  endtask

  task automatic cfg_read_check(input cfg_reg_e addr, input logic [CFG_DATA_W-1:0] exp);
    logic [CFG_DATA_W-1:0] rd;
    cfg_access(1'b0, addr, '0, rd);
    check_cfg_word($sformatf("cfg_r_data_o %s", addr.name()), rd, exp);
  endtask

  ////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////
  task automatic build_frame(input frame_t fr);
    int                      w;
    int                      h;
    pix_t                    x0;
    pix_t                    x1;
    pix_t                    y0;
    pix_t                    y1;
    logic signed [PIX_W+1:0] sum;
    w = int'(fr.width);
    h = int'(fr.height);
    for (int l = 0; l < N_LANES; l++) begin
      in_q[l].delete();
      exp_q[l].delete();
      for (int i = 0; i < w * h; i++) begin
        in_q[l].push_back(pix_t'(rand_bits(PIX_W)));
      end
      if (!fr.enable) begin
        exp_q[l] = in_q[l];
      end else begin
        for (int r = 0; r < h / 2; r++) begin
          for (int c = 0; c < w / 2; c++) begin
            x0 = in_q[l][2 * r * w + 2 * c];
            x1 = in_q[l][2 * r * w + 2 * c + 1];
            y0 = in_q[l][(2 * r + 1) * w + 2 * c];
            y1 = in_q[l][(2 * r + 1) * w + 2 * c + 1];
            if (fr.method == POOL_MAX) begin
              exp_q[l].push_back(max4(x0, x1, y0, y1));
            end else begin
              sum = SUM_W'(x0) + SUM_W'(x1) + SUM_W'(y0) + SUM_W'(y1);
              exp_q[l].push_back(pix_t'(sum >>> 2));
            end
          end
        end
      end
    end
  endtask

  // one clock of streaming sampled at the falling edge
  task automatic step_cycle(input logic rand_rdy, output int n_taken, output logic evt);
    logic rdy;
    @(posedge clk_fast_i);
    #1;
    for (int l = 0; l < N_LANES; l++) begin
      s_beat_i[l].valid = (in_q[l].size() != 0);
      s_beat_i[l].data  = (in_q[l].size() != 0) ? in_q[l][0] : '0;
    end
    rdy       = rand_rdy ? next_rand_bit() : 1'b1;
    m_ready_i = {N_LANES{rdy}};
    @(negedge clk_fast_i);
    n_taken = 0;
    for (int l = 0; l < N_LANES; l++) begin
      if (s_beat_i[l].valid && s_ready_o[l]) begin
        void'(in_q[l].pop_front());
      end
      if (m_beat_o[l].valid && m_ready_i[l]) begin
        if (exp_q[l].size() == 0) begin
          report_failure($sformatf("lane %0d delivered a result that was not expected", l));
        end else begin
          check_pix($sformatf("m_beat_o[%0d].data", l), m_beat_o[l].data, exp_q[l].pop_front());
          n_taken++;
        end
      end
    end
    evt = evt_interrupt_o;
  endtask

  task automatic run_frame(input int f);
    frame_t fr;
    int     pending;
    int     n_taken;
    logic   evt;
    fr        = FRAMES[f];
    cur_frame = f;
    cfg_write(REG_CTRL, {30'd0, fr.method, fr.enable});
    cfg_write(REG_WIDTH, 32'(fr.width));
    cfg_write(REG_HEIGHT, 32'(fr.height));
    cfg_read_check(REG_CTRL, {30'd0, fr.method, fr.enable});
    cfg_read_check(REG_WIDTH, 32'(fr.width));
    cfg_read_check(REG_HEIGHT, 32'(fr.height));
    build_frame(fr);
    pending = 0;
    for (int l = 0; l < N_LANES; l++) begin
      pending += exp_q[l].size();
    end
    // first pixel starts the frame and then the lock is probed
    step_cycle(fr.rand_rdy, n_taken, evt);
    check_event(evt, 1'b0);
    pending -= n_taken;
    cfg_read_check(REG_STATUS, 32'd1);
    cfg_write(REG_WIDTH, 32'(fr.width) + 32'd2);
    cfg_read_check(REG_WIDTH, 32'(fr.width));
    while (pending > 0) begin
      step_cycle(fr.rand_rdy, n_taken, evt);
      check_event(evt, 1'b0);
      pending -= n_taken;
    end
    step_cycle(fr.rand_rdy, n_taken, evt);
    check_event(evt, 1'b1);  // right after the last transfer
    step_cycle(fr.rand_rdy, n_taken, evt);
    check_event(evt, 1'b0);
    cfg_read_check(REG_STATUS, 32'd0);
  endtask

  initial begin
    rst_n       = 1'b0;
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    s_beat_i    = '0;
    m_ready_i   = '0;
    for (int f = 0; f < N_FRAMES; f++) begin
      timeout_limit += 4 * int'(FRAMES[f].width) * int'(FRAMES[f].height);
    end
    repeat (5) @(posedge clk_fast_i);
    #1;
    rst_n = 1'b1;

    // registers come up cleared
    cfg_read_check(REG_CTRL, '0);
    cfg_read_check(REG_WIDTH, '0);
    cfg_read_check(REG_HEIGHT, '0);
    cfg_read_check(REG_STATUS, '0);

    for (int f = 0; f < N_FRAMES; f++) begin
      run_frame(f);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
pool_cfg_pkg.sv
pool_stream_pkg.sv
pool_cfg_regs.sv
pool_input_slice.sv
pool_lane.sv
pool_output_collect.sv
pool_top.sv
pool_top_sva.sv
tb_pool_top.sv
